//--- flist.f
id_ctrl_pkg.sv
id_illegal_check.sv
id_hazard_unit.sv
id_exec_fsm.sv
id_redirect_gate.sv
id_stage_ctrl.sv
id_ctrl_properties.sv
tb_id_stage_ctrl.sv

//--- id_ctrl_pkg.sv
package id_ctrl_pkg;

  //////////////////////////////////////////////////
  // widths and build options
  //////////////////////////////////////////////////

  // register file address width
  localparam int unsigned REG_ADDR_W = 5;
  // data and instruction word width
  localparam int unsigned XLEN = 32;
  // no branch target ALU, so branch decisions are flopped one cycle
  localparam bit BRANCH_TARGET_ALU = 1'b0;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  // privilege levels (only user and machine modes exist)
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // execute class of the decoded instruction
  typedef enum logic [2:0] {
    OP_ALU       = 3'd0,
    OP_LSU       = 3'd1,
    OP_MULDIV    = 3'd2,
    OP_BRANCH    = 3'd3,
    OP_JUMP      = 3'd4,
    OP_ALU_MULTI = 3'd5
  } id_op_e;

  // ID/EX state machine
  typedef enum logic {
    FIRST_CYCLE = 1'b0,
    MULTI_CYCLE = 1'b1
  } id_fsm_e;

  // instruction type handed to writeback
  typedef enum logic [1:0] {
    WB_INSTR_LOAD  = 2'b00,
    WB_INSTR_STORE = 2'b01,
    WB_INSTR_OTHER = 2'b10
  } wb_instr_e;

  //////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////

  // decoded instruction sitting in ID/EX
  typedef struct packed {
    logic                  valid;
    id_op_e                op;
    logic                  is_mul;
    logic                  is_div;
    logic                  lsu_we;
    logic                  rf_we;
    logic                  rf_ren_a;
    logic                  rf_ren_b;
    logic [REG_ADDR_W-1:0] rf_raddr_a;
    logic [REG_ADDR_W-1:0] rf_raddr_b;
    logic                  fetch_err;
    logic                  illegal_dec;
    logic                  illegal_csr;
    logic                  mret;
    logic                  dret;
    logic                  wfi;
    logic                  ecall;
    logic                  ebrk;
    logic                  jump_set;
  } id_instr_t;

  // writeback and load/store state as seen from ID/EX
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rf_waddr_wb;
    logic                  outstanding_load;
    logic                  outstanding_store;
    logic                  lsu_resp_valid;
    logic                  lsu_req_done;
    logic                  ready_wb;
  } wb_status_t;

  // outcomes from the external controller
  typedef struct packed {
    logic controller_run;
    logic wb_exception;
    logic instr_valid_clear;
  } ctrl_status_t;

  // performance counter events
  typedef struct packed {
    logic branch;
    logic dside_wait;
    logic mul_wait;
    logic div_wait;
  } perf_t;

endpackage

//--- id_ctrl_properties.sv
`timescale 1ns/100ps

module id_ctrl_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic exec_i,
  input logic exec_spec_i,
  input logic done_i,
  input logic wb_exc_i,
  input logic branch_set_i,
  input logic jump_set_i,
  input logic valid_clear_i
);

  logic redirected_q;

  // remembers a redirect seen by fetch until the valid clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      redirected_q <= 1'b0;
    end else begin
      redirected_q <= (redirected_q | branch_set_i | jump_set_i) & ~valid_clear_i;
    end
  end

  //////////////////////////////////////////////////
  // execute and completion
  //////////////////////////////////////////////////

  // full execute is a subset of the speculative condition
  a_exec_in_spec: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exec_i |-> exec_spec_i)
    else $error("instruction executing without speculative execute");

  // a writeback exception kills the instruction in ID/EX
  a_no_done_on_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> !wb_exc_i)
    else $error("instruction completed during a writeback exception");

  //////////////////////////////////////////////////
  // redirects
  //////////////////////////////////////////////////

  // fetch sees at most one redirect source at a time
  a_one_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(branch_set_i && jump_set_i))
    else $error("branch and jump redirect raised together");

  // once redirected, nothing more until the valid clear
  a_one_redirect: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (branch_set_i || jump_set_i) |-> !redirected_q)
    else $error("second redirect for the same instruction");

endmodule

//--- id_exec_fsm.sv
`timescale 1ns/100ps

module id_exec_fsm import id_ctrl_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  id_instr_t    id_instr_i,
  input  wb_status_t   wb_status_i,
  input  ctrl_status_t ctrl_status_i,
  input  logic         ex_valid_i,
  input  logic         branch_decision_i,
  input  logic         data_ind_timing_i,
  input  logic         stall_ld_hz_i,
  input  logic         stall_mem_i,
  input  logic         outstanding_mem_i,
  output logic         branch_set_raw_d_o,
  output logic         jump_set_raw_o,
  output logic         rf_we_raw_o,
  output logic         instr_first_cycle_o,
  output logic         en_wb_o,
  output logic         instr_id_done_o,
  output wb_instr_e    instr_type_wb_o,
  output perf_t        perf_o
);

  id_fsm_e id_fsm_q, id_fsm_d;

  logic instr_kill;
  logic instr_executing_spec;
  logic instr_executing;
  logic stall_multdiv;
  logic stall_branch;
  logic stall_jump;
  logic stall_alu;
  logic stall_id;
  logic instr_done;
  logic multicycle_done;
  logic perf_branch;
  logic is_multi_ex;

  //////////////////////////////////////////////////
  // execute conditions
  //////////////////////////////////////////////////

  // killed instructions never execute
  assign instr_kill = id_instr_i.fetch_err | ctrl_status_i.wb_exception |
                      ~ctrl_status_i.controller_run;

  // speculative form ignores writeback exceptions and outstanding accesses
  // so redirects do not depend on the data-side response
  assign instr_executing_spec = id_instr_i.valid & ~id_instr_i.fetch_err &
                                ctrl_status_i.controller_run & ~stall_ld_hz_i;

  assign instr_executing = id_instr_i.valid & ~instr_kill & ~stall_ld_hz_i &
                           ~outstanding_mem_i;

  // lsu finishes when its memory stall clears, everything else on ex_valid
  assign multicycle_done = (id_instr_i.op == OP_LSU) ? ~stall_mem_i : ex_valid_i;

  // classes whose result comes from a multi-cycle unit
  assign is_multi_ex = (id_instr_i.op == OP_MULDIV) | (id_instr_i.op == OP_ALU_MULTI);

  //////////////////////////////////////////////////
  // id/ex state machine
  //////////////////////////////////////////////////

  // state only moves while the instruction really executes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q <= FIRST_CYCLE;
    end else if (instr_executing) begin
      id_fsm_q <= id_fsm_d;
    end
  end

  always_comb begin
    id_fsm_d           = id_fsm_q;
    rf_we_raw_o        = id_instr_i.rf_we;
    stall_multdiv      = 1'b0;
    stall_branch       = 1'b0;
    stall_jump         = 1'b0;
    stall_alu          = 1'b0;
    branch_set_raw_d_o = 1'b0;
    jump_set_raw_o     = 1'b0;
    perf_branch        = 1'b0;

    if (instr_executing_spec) begin
      unique case (id_fsm_q)
        FIRST_CYCLE: begin
          unique case (id_instr_i.op)
            OP_LSU: begin
              // hold address calculation until the request is granted
              if (!wb_status_i.lsu_req_done) begin
                id_fsm_d = MULTI_CYCLE;
              end
            end
            OP_MULDIV: begin
              // single cycle result can finish right away
              if (!ex_valid_i) begin
                id_fsm_d      = MULTI_CYCLE;
                rf_we_raw_o   = 1'b0;
                stall_multdiv = 1'b1;
              end
            end
            OP_BRANCH: begin
              // target computed next cycle, so a taken branch stalls once
              // data independent timing takes two cycles regardless of outcome
              id_fsm_d           = (data_ind_timing_i | branch_decision_i) ?
                                   MULTI_CYCLE : FIRST_CYCLE;
              stall_branch       = branch_decision_i | data_ind_timing_i;
              branch_set_raw_d_o = branch_decision_i | data_ind_timing_i;
              perf_branch        = 1'b1;
            end
            OP_JUMP: begin
              id_fsm_d       = BRANCH_TARGET_ALU ? FIRST_CYCLE : MULTI_CYCLE;
              stall_jump     = ~BRANCH_TARGET_ALU;
              jump_set_raw_o = id_instr_i.jump_set;
            end
            OP_ALU_MULTI: begin
              id_fsm_d    = MULTI_CYCLE;
              rf_we_raw_o = 1'b0;
              stall_alu   = 1'b1;
            end
            default: begin
              id_fsm_d = FIRST_CYCLE;
            end
          endcase
        end
        MULTI_CYCLE: begin
          // write only once the unit has its result
          if (is_multi_ex) begin
            rf_we_raw_o = id_instr_i.rf_we & ex_valid_i;
          end
          if (multicycle_done && wb_status_i.ready_wb) begin
            id_fsm_d = FIRST_CYCLE;
          end else begin
            stall_multdiv = (id_instr_i.op == OP_MULDIV);
            stall_branch  = (id_instr_i.op == OP_BRANCH);
            stall_jump    = (id_instr_i.op == OP_JUMP);
            stall_alu     = (id_instr_i.op == OP_ALU_MULTI);
          end
        end
        default: begin
          id_fsm_d = FIRST_CYCLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // stall merge and writeback handoff
  //////////////////////////////////////////////////

  assign stall_id = stall_ld_hz_i | stall_mem_i | stall_multdiv | stall_branch |
                    stall_jump | stall_alu;

  assign instr_done = ~stall_id & instr_executing;

  // ready for writeback, transfer happens when writeback accepts
  assign en_wb_o         = instr_done;
  assign instr_id_done_o = en_wb_o & wb_status_i.ready_wb;

  // held in first cycle while stalled before execution
  assign instr_first_cycle_o = id_instr_i.valid & (id_fsm_q == FIRST_CYCLE);

  assign instr_type_wb_o = (id_instr_i.op != OP_LSU) ? WB_INSTR_OTHER :
                           id_instr_i.lsu_we         ? WB_INSTR_STORE :
                                                       WB_INSTR_LOAD;

  // perf events
  assign perf_o.branch     = perf_branch;
  assign perf_o.dside_wait = id_instr_i.valid & ~instr_kill &
                             (outstanding_mem_i | stall_ld_hz_i);
  assign perf_o.mul_wait   = stall_multdiv & id_instr_i.is_mul;
  assign perf_o.div_wait   = stall_multdiv & id_instr_i.is_div;

endmodule

//--- id_hazard_unit.sv
`timescale 1ns/100ps

module id_hazard_unit import id_ctrl_pkg::*; (
  input  id_instr_t  id_instr_i,
  input  wb_status_t wb_status_i,
  output logic       stall_ld_hz_o,
  output logic       stall_mem_o,
  output logic       outstanding_mem_o
);

  logic rf_rd_a_wb_match;
  logic rf_rd_b_wb_match;
  logic rf_rd_a_hz;
  logic rf_rd_b_hz;
  logic outstanding_access;
  logic lsu_req_pending;

  //////////////////////////////////////////////////
  // load-use hazard
  //////////////////////////////////////////////////

  // read address equals the writeback destination
  // x0 never matches since it is never written
  assign rf_rd_a_wb_match = (wb_status_i.rf_waddr_wb == id_instr_i.rf_raddr_a) &
                            (|id_instr_i.rf_raddr_a);
  assign rf_rd_b_wb_match = (wb_status_i.rf_waddr_wb == id_instr_i.rf_raddr_b) &
                            (|id_instr_i.rf_raddr_b);

  // only a port that is really read can cause a hazard
  assign rf_rd_a_hz = rf_rd_a_wb_match & id_instr_i.rf_ren_a;
  assign rf_rd_b_hz = rf_rd_b_wb_match & id_instr_i.rf_ren_b;

  // load data arrives too late for forwarding, so wait
  assign stall_ld_hz_o = wb_status_i.outstanding_load & (rf_rd_a_hz | rf_rd_b_hz);

  //////////////////////////////////////////////////
  // memory stalls
  //////////////////////////////////////////////////

  // access in writeback still waiting for its response
  assign outstanding_access = (wb_status_i.outstanding_load | wb_status_i.outstanding_store) &
                              ~wb_status_i.lsu_resp_valid;

  // lsu instruction whose request has not been granted yet
  assign lsu_req_pending = (id_instr_i.op == OP_LSU) & ~wb_status_i.lsu_req_done;

  assign stall_mem_o       = id_instr_i.valid & (outstanding_access | lsu_req_pending);
  assign outstanding_mem_o = outstanding_access;

endmodule

//--- id_illegal_check.sv
`timescale 1ns/100ps

module id_illegal_check import id_ctrl_pkg::*; (
  input  id_instr_t id_instr_i,
  input  priv_lvl_e priv_mode_i,
  input  logic      csr_mstatus_tw_i,
  output logic      illegal_insn_o
);

  logic illegal_dret_insn;
  logic illegal_umode_insn;
  logic m_mode;

  //////////////////////////////////////////////////
  // privilege checks
  //////////////////////////////////////////////////

  assign m_mode = (priv_mode_i == PRIV_LVL_M);

  // there is no debug mode, so dret can never execute
  assign illegal_dret_insn = id_instr_i.dret;

  // mret needs machine mode
  // wfi traps to machine mode when TW is set
  assign illegal_umode_insn = ~m_mode &
                              (id_instr_i.mret | (csr_mstatus_tw_i & id_instr_i.wfi));

  //////////////////////////////////////////////////
  // final classification
  //////////////////////////////////////////////////

  // only a valid instruction can be illegal
  assign illegal_insn_o = id_instr_i.valid &
                          (id_instr_i.illegal_dec |
                           id_instr_i.illegal_csr |
                           illegal_dret_insn      |
                           illegal_umode_insn);

endmodule

//--- id_redirect_gate.sv
`timescale 1ns/100ps

module id_redirect_gate import id_ctrl_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic branch_set_raw_d_i,
  input  logic jump_set_raw_i,
  input  logic instr_valid_clear_i,
  output logic branch_set_o,
  output logic jump_set_o
);

  logic branch_set_raw_q;
  logic branch_set_raw;
  logic branch_jump_set_done_q;
  logic branch_jump_set_done_d;

  //////////////////////////////////////////////////
  // branch decision flop
  //////////////////////////////////////////////////

  // target is only ready the cycle after the decision
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      branch_set_raw_q <= 1'b0;
    end else begin
      branch_set_raw_q <= branch_set_raw_d_i;
    end
  end

  assign branch_set_raw = BRANCH_TARGET_ALU ? branch_set_raw_d_i : branch_set_raw_q;

  //////////////////////////////////////////////////
  // one redirect per instruction
  //////////////////////////////////////////////////

  // raw requests repeat while the instruction waits on memory,
  // remember that this instruction already redirected
  assign branch_jump_set_done_d = (branch_set_raw | jump_set_raw_i | branch_jump_set_done_q) &
                                  ~instr_valid_clear_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      branch_jump_set_done_q <= 1'b0;
    end else begin
      branch_jump_set_done_q <= branch_jump_set_done_d;
    end
  end

  // only the first pulse reaches fetch
  assign branch_set_o = branch_set_raw & ~branch_jump_set_done_q;
  assign jump_set_o   = jump_set_raw_i & ~branch_jump_set_done_q;

endmodule

//--- id_stage_ctrl.sv
`timescale 1ns/100ps

module id_stage_ctrl import id_ctrl_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  id_instr_t    id_instr_i,
  input  wb_status_t   wb_status_i,
  input  ctrl_status_t ctrl_status_i,
  input  priv_lvl_e    priv_mode_i,
  input  logic         csr_mstatus_tw_i,
  input  logic         branch_decision_i,
  input  logic         ex_valid_i,
  input  logic         data_ind_timing_i,
  output logic         illegal_insn_o,
  output logic         branch_set_o,
  output logic         jump_set_o,
  output logic         rf_we_raw_o,
  output logic         instr_first_cycle_o,
  output logic         en_wb_o,
  output logic         instr_id_done_o,
  output wb_instr_e    instr_type_wb_o,
  output perf_t        perf_o
);

  // hazard unit to fsm
  logic stall_ld_hz;
  logic stall_mem;
  logic outstanding_mem;
  // fsm to redirect gate
  logic branch_set_raw_d;
  logic jump_set_raw;

  id_illegal_check u_illegal (
    .id_instr_i       (id_instr_i),
    .priv_mode_i      (priv_mode_i),
    .csr_mstatus_tw_i (csr_mstatus_tw_i),
    .illegal_insn_o   (illegal_insn_o)
  );

  id_hazard_unit u_hazard (
    .id_instr_i        (id_instr_i),
    .wb_status_i       (wb_status_i),
    .stall_ld_hz_o     (stall_ld_hz),
    .stall_mem_o       (stall_mem),
    .outstanding_mem_o (outstanding_mem)
  );

  id_exec_fsm u_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .id_instr_i          (id_instr_i),
    .wb_status_i         (wb_status_i),
    .ctrl_status_i       (ctrl_status_i),
    .ex_valid_i          (ex_valid_i),
    .branch_decision_i   (branch_decision_i),
    .data_ind_timing_i   (data_ind_timing_i),
    .stall_ld_hz_i       (stall_ld_hz),
    .stall_mem_i         (stall_mem),
    .outstanding_mem_i   (outstanding_mem),
    .branch_set_raw_d_o  (branch_set_raw_d),
    .jump_set_raw_o      (jump_set_raw),
    .rf_we_raw_o         (rf_we_raw_o),
    .instr_first_cycle_o (instr_first_cycle_o),
    .en_wb_o             (en_wb_o),
    .instr_id_done_o     (instr_id_done_o),
    .instr_type_wb_o     (instr_type_wb_o),
    .perf_o              (perf_o)
  );

  // redirect tracker clears with the controller's valid clear
  id_redirect_gate u_redirect (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .branch_set_raw_d_i  (branch_set_raw_d),
    .jump_set_raw_i      (jump_set_raw),
    .instr_valid_clear_i (ctrl_status_i.instr_valid_clear),
    .branch_set_o        (branch_set_o),
    .jump_set_o          (jump_set_o)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the ID/EX control testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_id_stage_ctrl -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tb_id_stage_ctrl.sv
`timescale 1ns/100ps

module tb_id_stage_ctrl import id_ctrl_pkg::*; ();

  logic         clk_i = 1'b0;
  logic         rst_ni;
  id_instr_t    id_instr;
  wb_status_t   wb_status;
  ctrl_status_t ctrl_status;
  priv_lvl_e    priv_mode;
  logic         csr_tw;
  logic         branch_decision;
  logic         ex_valid;
  logic         data_ind_timing;
  logic         illegal_insn;
  logic         branch_set;
  logic         jump_set;
  logic         rf_we_raw;
  logic         instr_first_cycle;
  logic         en_wb;
  logic         instr_id_done;
  wb_instr_e    instr_type_wb;
  perf_t        perf;

  int           seed = 32'h91cb_fa09;
  int unsigned  checks;
  int unsigned  errors;
  // reference model state
  id_fsm_e      m_state;
  logic         m_bq;
  logic         m_tq;

  always #20 clk_i = ~clk_i;

  id_stage_ctrl dut_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .id_instr_i          (id_instr),
    .wb_status_i         (wb_status),
    .ctrl_status_i       (ctrl_status),
    .priv_mode_i         (priv_mode),
    .csr_mstatus_tw_i    (csr_tw),
    .branch_decision_i   (branch_decision),
    .ex_valid_i          (ex_valid),
    .data_ind_timing_i   (data_ind_timing),
    .illegal_insn_o      (illegal_insn),
    .branch_set_o        (branch_set),
    .jump_set_o          (jump_set),
    .rf_we_raw_o         (rf_we_raw),
    .instr_first_cycle_o (instr_first_cycle),
    .en_wb_o             (en_wb),
    .instr_id_done_o     (instr_id_done),
    .instr_type_wb_o     (instr_type_wb),
    .perf_o              (perf)
  );

  // internal invariants, each bind ties off the ports the other scope owns
  bind id_exec_fsm id_ctrl_properties u_fsm_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .exec_i        (instr_executing),
    .exec_spec_i   (instr_executing_spec),
    .done_i        (instr_id_done_o),
    .wb_exc_i      (ctrl_status_i.wb_exception),
    .branch_set_i  (1'b0),
    .jump_set_i    (1'b0),
    .valid_clear_i (1'b0)
  );

  bind id_redirect_gate id_ctrl_properties u_redirect_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .exec_i        (1'b0),
    .exec_spec_i   (1'b0),
    .done_i        (1'b0),
    .wb_exc_i      (1'b0),
    .branch_set_i  (branch_set_o),
    .jump_set_i    (jump_set_o),
    .valid_clear_i (instr_valid_clear_i)
  );

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_wb_type(input wb_instr_e got, input wb_instr_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t instr_type_wb_o: got %s, expected %s", $time, got.name(),
               exp.name());
    end
  endtask

  task automatic check_perf(input perf_t got, input perf_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t perf_o: got %b, expected %b", $time, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // reference model, checked mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin : ref_model
    logic      hz_a, hz_b, ld_hz, outst, mem_stall, kill, spec, exec;
    logic      cls_stall, fin, e_we, e_en, e_ill, b_raw, j_raw;
    id_fsm_e   nxt;
    perf_t     e_perf;
    wb_instr_e e_type;
    if (!rst_ni) begin
      m_state = FIRST_CYCLE;
      m_bq    = 1'b0;
      m_tq    = 1'b0;
    end else begin
      // read ports hitting the pending load destination, x0 excluded
      hz_a = id_instr.rf_ren_a && (id_instr.rf_raddr_a != '0) &&
             (id_instr.rf_raddr_a == wb_status.rf_waddr_wb);
      hz_b = id_instr.rf_ren_b && (id_instr.rf_raddr_b != '0) &&
             (id_instr.rf_raddr_b == wb_status.rf_waddr_wb);
      ld_hz = wb_status.outstanding_load && (hz_a || hz_b);
      outst = (wb_status.outstanding_load || wb_status.outstanding_store) &&
              !wb_status.lsu_resp_valid;
      mem_stall = id_instr.valid &&
                  (outst || (id_instr.op == OP_LSU && !wb_status.lsu_req_done));
      kill = id_instr.fetch_err || ctrl_status.wb_exception || !ctrl_status.controller_run;
      spec = id_instr.valid && !id_instr.fetch_err && ctrl_status.controller_run && !ld_hz;
      exec = id_instr.valid && !kill && !ld_hz && !outst;
      e_ill = id_instr.valid && (id_instr.illegal_dec || id_instr.illegal_csr ||
              id_instr.dret || (priv_mode != PRIV_LVL_M &&
              (id_instr.mret || (csr_tw && id_instr.wfi))));
      nxt       = m_state;
      e_we      = id_instr.rf_we;
      cls_stall = 1'b0;
      b_raw     = 1'b0;
      j_raw     = 1'b0;
      e_perf    = '0;
      if (spec && m_state == FIRST_CYCLE) begin
        case (id_instr.op)
          OP_LSU: begin
            if (!wb_status.lsu_req_done) begin
              nxt = MULTI_CYCLE;
            end
          end
          OP_MULDIV: begin
            if (!ex_valid) begin
              nxt       = MULTI_CYCLE;
              e_we      = 1'b0;
              cls_stall = 1'b1;
            end
          end
          OP_BRANCH: begin
            // taken or fixed-time branches wait one cycle for the target
            b_raw         = branch_decision || data_ind_timing;
            nxt           = b_raw ? MULTI_CYCLE : FIRST_CYCLE;
            cls_stall     = b_raw;
            e_perf.branch = 1'b1;
          end
          OP_JUMP: begin
            nxt       = MULTI_CYCLE;
            cls_stall = 1'b1;
            j_raw     = id_instr.jump_set;
          end
          OP_ALU_MULTI: begin
            nxt       = MULTI_CYCLE;
            e_we      = 1'b0;
            cls_stall = 1'b1;
          end
          default: begin
            nxt = FIRST_CYCLE;
          end
        endcase
      end else if (spec) begin
        fin = (id_instr.op == OP_LSU) ? !mem_stall : ex_valid;
        if (id_instr.op == OP_MULDIV || id_instr.op == OP_ALU_MULTI) begin
          e_we = id_instr.rf_we && ex_valid;
        end
        if (fin && wb_status.ready_wb) begin
          nxt = FIRST_CYCLE;
        end else begin
          cls_stall = (id_instr.op != OP_ALU) && (id_instr.op != OP_LSU);
        end
      end
      e_en              = exec && !ld_hz && !mem_stall && !cls_stall;
      e_perf.dside_wait = id_instr.valid && !kill && (outst || ld_hz);
      e_perf.mul_wait   = cls_stall && id_instr.op == OP_MULDIV && id_instr.is_mul;
      e_perf.div_wait   = cls_stall && id_instr.op == OP_MULDIV && id_instr.is_div;

      // loads and stores are the lsu class split by lsu_we
      if (id_instr.op == OP_LSU && id_instr.lsu_we) begin
        e_type = WB_INSTR_STORE;
      end else if (id_instr.op == OP_LSU) begin
        e_type = WB_INSTR_LOAD;
      end else begin
        e_type = WB_INSTR_OTHER;
      end

      check_bit("illegal_insn_o", illegal_insn, e_ill);
      check_bit("rf_we_raw_o", rf_we_raw, e_we);
      check_bit("instr_first_cycle_o", instr_first_cycle,
                id_instr.valid && m_state == FIRST_CYCLE);
      check_bit("en_wb_o", en_wb, e_en);
      check_bit("instr_id_done_o", instr_id_done, e_en && wb_status.ready_wb);
      check_bit("branch_set_o", branch_set, m_bq && !m_tq);
      check_bit("jump_set_o", jump_set, j_raw && !m_tq);
      check_wb_type(instr_type_wb, e_type);
      check_perf(perf, e_perf);

      // registered state advances at the coming edge
      if (exec) begin
        m_state = nxt;
      end
      m_tq = (m_bq || j_raw || m_tq) && !ctrl_status.instr_valid_clear;
      m_bq = b_raw;
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  function automatic bit coin(input int unsigned pct);
    int unsigned v;
    v = $unsigned($random(seed)) % 100;
    return v < pct;
  endfunction

  function automatic id_op_e pick_op();
    case ($unsigned($random(seed)) % 6)
      0: return OP_ALU;
      1: return OP_LSU;
      2: return OP_MULDIV;
      3: return OP_BRANCH;
      4: return OP_JUMP;
      default: return OP_ALU_MULTI;
    endcase
  endfunction

  // hazard runs use x0..x3 so matches and x0 reads are common
  function automatic id_instr_t rand_instr(input id_op_e op, input bit hz);
    id_instr_t       ins;
    logic [XLEN-1:0] r;
    r              = $random(seed);
    ins            = '0;
    ins.valid      = 1'b1;
    ins.op         = op;
    ins.is_mul     = (op == OP_MULDIV) && coin(50);
    ins.is_div     = (op == OP_MULDIV) && !ins.is_mul;
    ins.lsu_we     = coin(50);
    ins.rf_we      = coin(70);
    ins.rf_ren_a   = coin(70);
    ins.rf_ren_b   = coin(50);
    ins.rf_raddr_a = hz ? {3'b000, r[1:0]} : r[4:0];
    ins.rf_raddr_b = hz ? {3'b000, r[6:5]} : r[9:5];
    ins.illegal_dec = coin(10);
    ins.illegal_csr = coin(10);
    ins.mret       = coin(15);
    ins.dret       = coin(5);
    ins.wfi        = coin(15);
    ins.ecall      = coin(5);
    ins.ebrk       = coin(5);
    ins.jump_set   = (op == OP_JUMP) && coin(85);
    return ins;
  endfunction

  task automatic drive_status(input bit hz, input bit kill);
    wb_status_t      ws;
    ctrl_status_t    cs;
    logic [XLEN-1:0] r;
    bit              k;
    r                    = $random(seed);
    ws.rf_waddr_wb       = hz ? {3'b000, r[1:0]} : r[4:0];
    ws.outstanding_load  = coin(hz ? 50 : 25);
    ws.outstanding_store = coin(15);
    ws.lsu_resp_valid    = coin(60);
    ws.lsu_req_done      = coin(70);
    ws.ready_wb          = coin(70);
    // a kill is either the controller halted or a writeback exception
    k                    = coin(50);
    cs.controller_run    = !(kill && k);
    cs.wb_exception      = kill && !k;
    cs.instr_valid_clear = 1'b0;
    wb_status   <= ws;
    ctrl_status <= cs;
    ex_valid    <= coin(40);
    priv_mode   <= coin(50) ? PRIV_LVL_M : PRIV_LVL_U;
    csr_tw      <= coin(50);
  endtask

  // hold one instruction until done or the cycle limit, then a clear bubble
  task automatic run_instr(input id_instr_t ins, input logic dec, input logic dit,
                           input bit hz, input int unsigned kill_cycles,
                           input int unsigned max_cycles,
                           output int unsigned bp, output int unsigned jp);
    int unsigned n;
    bit          done;
    n    = 0;
    done = 1'b0;
    bp   = 0;
    jp   = 0;
    while (!done && n < max_cycles) begin
      @(posedge clk_i);
      id_instr        <= ins;
      branch_decision <= dec;
      data_ind_timing <= dit;
      drive_status(hz, n < kill_cycles);
      @(negedge clk_i);
      if (branch_set) begin
        bp++;
      end
      if (jump_set) begin
        jp++;
      end
      if (n < kill_cycles) begin
        check_bit("completion while killed", instr_id_done, 1'b0);
      end
      done = instr_id_done;
      n++;
    end
    if (!done) begin
      errors++;
      $display("instruction op %s did not complete within %0d cycles", ins.op.name(),
               max_cycles);
    end
    @(posedge clk_i);
    id_instr    <= '0;
    ctrl_status <= '{controller_run: 1'b1, wb_exception: 1'b0, instr_valid_clear: 1'b1};
  endtask

  task automatic run_one(input id_op_e op, input bit hz, input bit kill);
    id_instr_t   ins;
    logic        dec;
    logic        dit;
    logic        taken;
    int unsigned kill_cycles;
    int unsigned max_cycles;
    int unsigned bp;
    int unsigned jp;
    ins         = rand_instr(op, hz);
    dec         = coin(50);
    dit         = coin(25);
    taken       = (op == OP_BRANCH) && (dec || dit);
    kill_cycles = kill ? 1 + ($unsigned($random(seed)) % 3) : 0;
    max_cycles  = 64 + kill_cycles;
    run_instr(ins, dec, dit, hz, kill_cycles, max_cycles, bp, jp);
    check_bit("branch redirect count", bp == (taken ? 1 : 0), 1'b1);
    check_bit("jump redirect count", jp == ((op == OP_JUMP && ins.jump_set) ? 1 : 0), 1'b1);
  endtask

  task automatic run_test(input string name, input int unsigned sel, input int unsigned count);
    int unsigned i;
    int unsigned chk0;
    int unsigned err0;
    id_op_e      op;
    chk0 = checks;
    err0 = errors;
    for (i = 0; i < count; i++) begin
      case (sel)
        2: op = OP_ALU;
        3: op = i[0] ? OP_MULDIV : OP_ALU_MULTI;
        4: op = OP_BRANCH;
        5: op = OP_JUMP;
        6: op = coin(50) ? OP_LSU : pick_op();
        default: op = pick_op();
      endcase
      run_one(op, sel == 2, sel == 6);
    end
    $display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    id_instr        = '0;
    wb_status       = '0;
    ctrl_status     = '0;
    priv_mode       = PRIV_LVL_M;
    csr_tw          = 1'b0;
    branch_decision = 1'b0;
    ex_valid        = 1'b0;
    data_ind_timing = 1'b0;
    rst_ni          = 1'b0;
    checks          = 0;
    errors          = 0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    run_test("illegal classification", 1, 40);
    run_test("load-use hazards", 2, 40);
    run_test("mul/div and multi-cycle alu", 3, 40);
    run_test("branches", 4, 40);
    run_test("jumps", 5, 40);
    run_test("writeback type and kills", 6, 40);
    @(negedge clk_i);
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // hang guard
  initial begin
    #1_000_000;
    $display("simulation time limit reached before all tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
